/* source/mcr2_inputs_config.svh */
// Loader indices, DIP bank size, spinner steps, stick values and idle port value
`ifndef MCR2_INPUTS_CONFIG_SVH
`define MCR2_INPUTS_CONFIG_SVH

// ====================
// Loader stream
// ====================
// Index that carries the game code
`define MCR2_IDX_GAME 8'd1
// Index that carries the DIP bank
`define MCR2_IDX_DIP 8'd254
`define MCR2_DIP_BYTES 8

// ====================
// Counters and ports
// ====================
// Position change per vsync rise
`define MCR2_STEP_ROT 12
`define MCR2_STEP_TIGER 25
`define MCR2_STEP_TRACK 10

// Krooz'r stick, rest position and deflection
`define MCR2_STICK_CENTER 8'd100
`define MCR2_STICK_SWING 8'd63

`define MCR2_PORT_IDLE 8'hff
`endif

/* source/mcr2_inputs_pkg.sv */
// Byte, loader field, game and player control types of the cabinet inputs
package mcr2_inputs_pkg;

	// One board port or counter position
	typedef logic [7:0] port_byte_t;
	typedef logic [7:0] loader_index_t;
	typedef logic [24:0] loader_addr_t;

	// Game codes as sent by the loader, in code order
	typedef enum logic [2:0] {
		GAME_SHOLLOW  = 3'd0,
		GAME_TRON     = 3'd1,
		GAME_TWOTIGER = 3'd2,
		GAME_WACKO    = 3'd3,
		GAME_KROOZR   = 3'd4,
		GAME_DOMINO   = 3'd5,
		GAME_NONE     = 3'd6
	} game_id_t;

	// One player, all active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic rot_cw;
		logic rot_ccw;
		logic start1;
		logic start2;
		logic coin;
	} player_ctrl_t;

	typedef struct packed {
		logic          wr;
		loader_index_t index;
		loader_addr_t  addr;
		port_byte_t    data;
	} loader_wr_t;

	typedef struct packed {
		port_byte_t input_0;
		port_byte_t input_1;
		port_byte_t input_2;
		port_byte_t input_3;
		port_byte_t input_4;
	} cab_ports_t;

endpackage

/* source/dl_decoder.sv */
// Loader write decoder holding the selected game and the DIP switch bank
`timescale 1ns/1ps
`include "mcr2_inputs_config.svh"

module dl_decoder (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  mcr2_inputs_pkg::loader_wr_t   loader,
	output mcr2_inputs_pkg::game_id_t     game,
	output mcr2_inputs_pkg::port_byte_t   dip_0,
	output logic                          service
);
	import mcr2_inputs_pkg::*;

	localparam int DIP_AW = $clog2(`MCR2_DIP_BYTES);

	port_byte_t dip [`MCR2_DIP_BYTES];
	logic game_wr;
	logic dip_wr;
	game_id_t game_code;

	// ====================
	// Write decode
	// ====================
	assign game_wr = loader.wr && (loader.index == `MCR2_IDX_GAME);

	// Only the first bank bytes are stored, higher addresses are dropped
	assign dip_wr = loader.wr && (loader.index == `MCR2_IDX_DIP)
		&& (loader.addr < loader_addr_t'(`MCR2_DIP_BYTES));

	// Codes past the last game select nothing
	always_comb begin
		if (loader.data < port_byte_t'(GAME_NONE)) begin
			game_code = game_id_t'(loader.data[2:0]);
		end else begin
			game_code = GAME_NONE;
		end
	end

	// ====================
	// State
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game <= GAME_SHOLLOW;
			for (int i = 0; i < `MCR2_DIP_BYTES; i++) begin
				dip[i] <= `MCR2_PORT_IDLE;
			end
		end else begin
			if (game_wr) begin
				game <= game_code;
			end
			if (dip_wr) begin
				dip[loader.addr[DIP_AW-1:0]] <= loader.data;
			end
		end
	end

	// Byte 0 goes to the board, byte 1 bit 0 is the service switch
	assign dip_0 = dip[0];
	assign service = dip[1][0];

endmodule

/* source/spinner.sv */
// Position counter stepped up or down on each rising edge of vertical sync
`timescale 1ns/1ps

module spinner #(
	parameter int STEP = 1
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        plus,
	input  logic                        minus,
	input  logic                        vsync,
	output mcr2_inputs_pkg::port_byte_t position
);
	import mcr2_inputs_pkg::*;

	localparam port_byte_t STEP_VAL = port_byte_t'(STEP);

	logic vsync_q;
	logic vsync_rise;

	// One step per frame
	assign vsync_rise = vsync & ~vsync_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_q <= 1'b0;
			position <= '0;
		end else begin
			vsync_q <= vsync;
			if (vsync_rise) begin
				// Both or neither pressed holds the position
				if (plus && !minus) begin
					position <= position + STEP_VAL;
				end else if (minus && !plus) begin
					position <= position - STEP_VAL;
				end
			end
		end
	end

	// Eight bit arithmetic wraps on its own

endmodule

/* source/port_mapper.sv */
// Player merge and per-game assembly of the registered board ports and orientation
`timescale 1ns/1ps
`include "mcr2_inputs_config.svh"

module port_mapper (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  mcr2_inputs_pkg::game_id_t     game,
	input  mcr2_inputs_pkg::port_byte_t   dip_0,
	input  logic                          service,
	input  mcr2_inputs_pkg::player_ctrl_t p1,
	input  mcr2_inputs_pkg::player_ctrl_t p2,
	input  mcr2_inputs_pkg::port_byte_t   spin_rot,
	input  mcr2_inputs_pkg::port_byte_t   spin_tiger1,
	input  mcr2_inputs_pkg::port_byte_t   spin_tiger2,
	input  mcr2_inputs_pkg::port_byte_t   track_x,
	input  mcr2_inputs_pkg::port_byte_t   track_y,
	output mcr2_inputs_pkg::cab_ports_t   ports,
	output logic                          orientation
);
	import mcr2_inputs_pkg::*;

	player_ctrl_t m;
	logic fire_x;
	cab_ports_t ports_next;
	logic orientation_next;

	// Analog stick value, the decrementing direction wins
	function automatic port_byte_t stick_value(input logic dec, input logic inc);
		port_byte_t value;
		if (dec) begin
			value = `MCR2_STICK_CENTER - `MCR2_STICK_SWING;
		end else if (inc) begin
			value = `MCR2_STICK_CENTER + `MCR2_STICK_SWING;
		end else begin
			value = `MCR2_STICK_CENTER;
		end
		return value;
	endfunction

	// Both players share one set of cabinet controls
	assign m = p1 | p2;

	// Bit 4 of the coin/start byte
	always_comb begin
		case (game)
			GAME_SHOLLOW, GAME_WACKO: fire_x = 1'b0;
			GAME_TWOTIGER: fire_x = m.fire_c;
			default: fire_x = m.fire_a;
		endcase
	end

	// ====================
	// Port layout
	// ====================
	always_comb begin
		ports_next.input_0 = `MCR2_PORT_IDLE;
		ports_next.input_1 = `MCR2_PORT_IDLE;
		ports_next.input_2 = `MCR2_PORT_IDLE;
		ports_next.input_3 = dip_0;
		ports_next.input_4 = `MCR2_PORT_IDLE;
		orientation_next = 1'b0;

		if (game != GAME_NONE) begin
			ports_next.input_0 = ~{service, 2'b00, fire_x, m.start2, m.start1, 1'b0, m.coin};
		end

		case (game)
			GAME_SHOLLOW: begin
				ports_next.input_1 = ~{2{m.fire_a, m.fire_b, m.right, m.left}};
			end
			GAME_TRON: begin
				ports_next.input_1 = ~{1'b0, spin_rot[7:1]};
				ports_next.input_2 = ~{2{m.down, m.up, m.right, m.left}};
				ports_next.input_3[7] = ~m.fire_a;
				ports_next.input_4 = ~{1'b0, spin_rot[7:1]};
			end
			GAME_TWOTIGER: begin
				orientation_next = 1'b1;
				ports_next.input_1 = ~{1'b0, spin_tiger1[7:1]};
				// Fire buttons stay per player here
				ports_next.input_2 = ~{4'b0000, p2.fire_b, p2.fire_a, p1.fire_b, p1.fire_a};
				ports_next.input_4 = ~{1'b0, spin_tiger2[7:1]};
			end
			GAME_WACKO: begin
				orientation_next = 1'b1;
				ports_next.input_1 = track_x;
				ports_next.input_2 = track_y;
				ports_next.input_4 = ~{2{m.fire_c, m.fire_b, m.fire_d, m.fire_a}};
			end
			GAME_KROOZR: begin
				orientation_next = 1'b1;
				ports_next.input_1 = ~{m.fire_b, spin_rot[7], 3'b000, spin_rot[6:4]};
				ports_next.input_2 = stick_value(m.left, m.right);
				ports_next.input_4 = stick_value(m.up, m.down);
			end
			GAME_DOMINO: begin
				orientation_next = 1'b1;
				ports_next.input_1 = ~{4'b0000, m.down, m.up, m.right, m.left};
				ports_next.input_2 = ~{3'b000, m.fire_a, m.down, m.up, m.right, m.left};
			end
			// No game, only the DIP byte is visible
			default: ;
		endcase
	end

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ports <= {5{`MCR2_PORT_IDLE}};
			orientation <= 1'b0;
		end else begin
			ports <= ports_next;
			orientation <= orientation_next;
		end
	end

endmodule

/* source/mcr2_inputs.sv */
// Cabinet input section top level with loader decoder, position counters and port mapper
`timescale 1ns/1ps
`include "mcr2_inputs_config.svh"

module mcr2_inputs (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  mcr2_inputs_pkg::loader_wr_t   loader,
	input  mcr2_inputs_pkg::player_ctrl_t p1,
	input  mcr2_inputs_pkg::player_ctrl_t p2,
	input  logic                          vsync,
	output mcr2_inputs_pkg::cab_ports_t   ports,
	output logic                          orientation
);
	import mcr2_inputs_pkg::*;

	game_id_t game;
	port_byte_t dip_0;
	logic service;
	port_byte_t spin_rot;
	port_byte_t spin_tiger1;
	port_byte_t spin_tiger2;
	port_byte_t track_x;
	port_byte_t track_y;

	dl_decoder u_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.loader  (loader),
		.game    (game),
		.dip_0   (dip_0),
		.service (service)
	);

	// ====================
	// Counters
	// ====================
	// Rotary knob for Tron and Krooz'r, either player turns it
	spinner #(.STEP(`MCR2_STEP_ROT)) u_spin_rot (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.plus     (p1.rot_cw | p2.rot_cw),
		.minus    (p1.rot_ccw | p2.rot_ccw),
		.vsync    (vsync),
		.position (spin_rot)
	);

	// Two Tigers, one dial per player
	spinner #(.STEP(`MCR2_STEP_TIGER)) u_spin_tiger1 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.plus     (p1.rot_cw | p1.right),
		.minus    (p1.rot_ccw | p1.left),
		.vsync    (vsync),
		.position (spin_tiger1)
	);

	spinner #(.STEP(`MCR2_STEP_TIGER)) u_spin_tiger2 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.plus     (p2.rot_cw | p2.right),
		.minus    (p2.rot_ccw | p2.left),
		.vsync    (vsync),
		.position (spin_tiger2)
	);

	// Wacko trackball from the merged stick
	spinner #(.STEP(`MCR2_STEP_TRACK)) u_track_x (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.plus     (p1.right | p2.right),
		.minus    (p1.left | p2.left),
		.vsync    (vsync),
		.position (track_x)
	);

	spinner #(.STEP(`MCR2_STEP_TRACK)) u_track_y (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.plus     (p1.up | p2.up),
		.minus    (p1.down | p2.down),
		.vsync    (vsync),
		.position (track_y)
	);

	port_mapper u_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game        (game),
		.dip_0       (dip_0),
		.service     (service),
		.p1          (p1),
		.p2          (p2),
		.spin_rot    (spin_rot),
		.spin_tiger1 (spin_tiger1),
		.spin_tiger2 (spin_tiger2),
		.track_x     (track_x),
		.track_y     (track_y),
		.ports       (ports),
		.orientation (orientation)
	);

endmodule

/* test/mcr2_inputs_props.sv */
// Bound assertions on reset values, orientation per game and ignored loader writes
`timescale 1ns/1ps
`include "mcr2_inputs_config.svh"

module mcr2_inputs_props (
	input logic                        clk_sys,
	input logic                        reset,
	input mcr2_inputs_pkg::loader_wr_t loader,
	input mcr2_inputs_pkg::game_id_t   game,
	input mcr2_inputs_pkg::port_byte_t dip_0,
	input logic                        service,
	input mcr2_inputs_pkg::cab_ports_t ports,
	input logic                        orientation
);
	import mcr2_inputs_pkg::*;

	logic foreign_wr;
	logic landscape_game;

	// Writes to neither the game nor the DIP index
	assign foreign_wr = loader.wr && (loader.index != `MCR2_IDX_GAME)
		&& (loader.index != `MCR2_IDX_DIP);
	assign landscape_game = game inside {GAME_TWOTIGER, GAME_WACKO, GAME_KROOZR, GAME_DOMINO};

	reset_idle: assert property (@(posedge clk_sys)
		reset |=> (ports == {5{`MCR2_PORT_IDLE}}) && !orientation)
		else $error("ports not idle after reset");

	// Orientation is registered from the game one edge earlier
	orient_game: assert property (@(posedge clk_sys) disable iff (reset)
		orientation |-> $past(landscape_game))
		else $error("orientation set for a game that is not landscape");

	foreign_ignored: assert property (@(posedge clk_sys) disable iff (reset)
		foreign_wr |=> $stable(game) && $stable(dip_0) && $stable(service))
		else $error("loader write to another index changed the decoder");

endmodule

bind mcr2_inputs mcr2_inputs_props props (
	.clk_sys(clk_sys), .reset(reset), .loader(loader), .game(game),
	.dip_0(dip_0), .service(service), .ports(ports), .orientation(orientation)
);

/* test/tb_mcr2_inputs.sv */
// Testbench for the cabinet inputs with LFSR stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`include "mcr2_inputs_config.svh"

module tb_mcr2_inputs;
	import mcr2_inputs_pkg::*;

	localparam int CLK_PERIOD = 8;
	// Cycles of all six tests plus a margin
	localparam int WATCHDOG_NS = (10 + 980 + 60 + 320 + 70 + 30 + 200) * CLK_PERIOD;

	logic clk_sys = 1'b0;
	logic reset;
	loader_wr_t loader;
	player_ctrl_t p1;
	player_ctrl_t p2;
	logic vsync;
	cab_ports_t ports;
	logic orientation;

	// Model state with counters in order rot, tiger1, tiger2, track x and track y
	logic [31:0] lfsr_state = 32'h33584afc;
	int model_game;
	port_byte_t dip_bank [`MCR2_DIP_BYTES];
	port_byte_t cnt [5];
	player_ctrl_t cur_p1;
	player_ctrl_t cur_p2;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_failed = 0;
	string first_msg;

	mcr2_inputs dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic player_ctrl_t rand_ctrl();
		logic [31:0] r;
		r = lfsr_bits(13);
		return r[12:0];
	endfunction

	// One frame of a counter where opposite or no direction holds
	function automatic port_byte_t stepped(input port_byte_t pos, input logic up,
			input logic dn, input int step);
		if (up == dn) begin
			return pos;
		end
		return up ? pos + port_byte_t'(step) : pos - port_byte_t'(step);
	endfunction

	// ====================
	// Reference layout
	// ====================
	function automatic cab_ports_t model_ports(input player_ctrl_t a, input player_ctrl_t b);
		player_ctrl_t m;
		cab_ports_t e;
		m = a | b;
		e = {5{8'hff}};
		e.input_3 = dip_bank[0];
		if (model_game < 6) begin
			// Active low coin and start byte with the service switch on top
			e.input_0[7] = ~dip_bank[1][0];
			e.input_0[3] = ~m.start2;
			e.input_0[2] = ~m.start1;
			e.input_0[0] = ~m.coin;
			if (model_game == 2) begin
				e.input_0[4] = ~m.fire_c;
			end else if (model_game != 0 && model_game != 3) begin
				e.input_0[4] = ~m.fire_a;
			end
		end
		case (model_game)
			0: e.input_1 = ~{2{m.fire_a, m.fire_b, m.right, m.left}};
			1: begin
				e.input_1 = {1'b1, ~cnt[0][7:1]};
				e.input_2 = ~{m.down, m.up, m.right, m.left, m.down, m.up, m.right, m.left};
				e.input_3[7] = ~m.fire_a;
				e.input_4 = e.input_1;
			end
			2: begin
				e.input_1 = {1'b1, ~cnt[1][7:1]};
				e.input_2 = {4'hf, ~b.fire_b, ~b.fire_a, ~a.fire_b, ~a.fire_a};
				e.input_4 = {1'b1, ~cnt[2][7:1]};
			end
			3: begin
				e.input_1 = cnt[3];
				e.input_2 = cnt[4];
				e.input_4 = ~{2{m.fire_c, m.fire_b, m.fire_d, m.fire_a}};
			end
			4: begin
				// Stick rests at 100 and swings by 63
				e.input_1 = {~m.fire_b, ~cnt[0][7], 3'b111, ~cnt[0][6:4]};
				e.input_2 = m.left ? 8'd37 : (m.right ? 8'd163 : 8'd100);
				e.input_4 = m.up ? 8'd37 : (m.down ? 8'd163 : 8'd100);
			end
			5: begin
				e.input_1 = {4'hf, ~m.down, ~m.up, ~m.right, ~m.left};
				e.input_2 = {3'b111, ~m.fire_a, ~m.down, ~m.up, ~m.right, ~m.left};
			end
			default: ;
		endcase
		return e;
	endfunction

	// ====================
	// Drivers and checks
	// ====================
	task automatic drive_controls(input player_ctrl_t a, input player_ctrl_t b, input logic vs);
		player_ctrl_t m;
		m = a | b;
		@(posedge clk_sys);
		p1 <= a;
		p2 <= b;
		vsync <= vs;
		cur_p1 = a;
		cur_p2 = b;
		if (vs) begin
			cnt[0] = stepped(cnt[0], m.rot_cw, m.rot_ccw, `MCR2_STEP_ROT);
			cnt[1] = stepped(cnt[1], a.rot_cw | a.right, a.rot_ccw | a.left, `MCR2_STEP_TIGER);
			cnt[2] = stepped(cnt[2], b.rot_cw | b.right, b.rot_ccw | b.left, `MCR2_STEP_TIGER);
			cnt[3] = stepped(cnt[3], m.right, m.left, `MCR2_STEP_TRACK);
			cnt[4] = stepped(cnt[4], m.up, m.down, `MCR2_STEP_TRACK);
			@(posedge clk_sys);
			vsync <= 1'b0;
		end
	endtask

	task automatic load_write(input loader_index_t idx, input loader_addr_t addr,
			input port_byte_t data);
		@(posedge clk_sys);
		loader <= '{wr: 1'b1, index: idx, addr: addr, data: data};
		@(posedge clk_sys);
		loader.wr <= 1'b0;
		if (idx == `MCR2_IDX_GAME) begin
			model_game = (data < 8'd6) ? int'(data) : 6;
		end else if (idx == `MCR2_IDX_DIP && addr < 25'd8) begin
			dip_bank[addr[2:0]] = data;
		end
	endtask

	task automatic check_ports(input string what);
		cab_ports_t exp;
		logic exp_orient;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		exp = model_ports(cur_p1, cur_p2);
		exp_orient = (model_game >= 2 && model_game <= 5);
		checks++;
		if (ports !== exp || orientation !== exp_orient) begin
			if (test_errors == 0) begin
				first_msg = $sformatf(
					"mismatch at %0t: %s, ports %h orientation %b, expected %h %b",
					$time, what, ports, orientation, exp, exp_orient);
			end
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errors != 0) begin
			$display("%s (test %s, %0d wrong)", first_msg, name, test_errors);
			errors += test_errors;
			tests_failed++;
		end else begin
			$display("test %s passed", name);
		end
		test_errors = 0;
	endtask

	initial begin
		logic [31:0] r;
		player_ctrl_t a;
		player_ctrl_t b;
		reset = 1'b1;
		loader = '0;
		p1 = '0;
		p2 = '0;
		vsync = 1'b0;
		model_game = 0;
		cur_p1 = '0;
		cur_p2 = '0;
		cnt = '{default: '0};
		dip_bank = '{default: 8'hff};
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// Reset values still visible before the first registered update
		@(negedge clk_sys);
		checks++;
		if (ports !== {5{8'hff}} || orientation !== 1'b0) begin
			first_msg = $sformatf("mismatch at %0t: reset ports %h orientation %b",
				$time, ports, orientation);
			test_errors++;
		end
		end_test("reset");

		for (int g = 0; g < 6; g++) begin
			load_write(`MCR2_IDX_GAME, '0, port_byte_t'(g));
			for (int i = 0; i < 40; i++) begin
				a = rand_ctrl();
				b = rand_ctrl();
				drive_controls(a, b, 1'b0);
				check_ports($sformatf("game %0d vector %0d", g, i));
			end
		end
		end_test("game layouts");

		for (int i = 0; i < 8; i++) begin
			r = lfsr_bits(8);
			load_write(`MCR2_IDX_DIP, loader_addr_t'(i), r[7:0]);
			check_ports($sformatf("DIP byte %0d", i));
		end
		// Address past the bank and an index nobody decodes
		// Bit 0 differs from the stored service bit so an aliased write would show
		r = lfsr_bits(8);
		load_write(`MCR2_IDX_DIP, 25'd9, {r[7:1], ~dip_bank[1][0]});
		load_write(8'd7, '0, ~r[7:0]);
		check_ports("ignored writes");
		end_test("DIP loading");

		for (int i = 0; i < 60; i++) begin
			if (i % 30 == 0) begin
				load_write(`MCR2_IDX_GAME, '0, (i == 0) ? 8'd1 : 8'd2);
			end
			a = rand_ctrl();
			b = rand_ctrl();
			if (i % 5 == 4) begin
				a.rot_cw = 1'b1;
				a.rot_ccw = 1'b1;
				a.right = 1'b1;
				a.left = 1'b1;
			end
			drive_controls(a, b, 1'b1);
			check_ports($sformatf("vsync pulse %0d", i));
		end
		// Trackball positions reached by the same pulses
		load_write(`MCR2_IDX_GAME, '0, 8'd3);
		check_ports("trackball positions");
		end_test("spinners");

		load_write(`MCR2_IDX_GAME, '0, 8'd4);
		for (int i = 0; i < 16; i++) begin
			a = '0;
			b = '0;
			a.left = i[0];
			b.right = i[1];
			a.up = i[2];
			b.down = i[3];
			drive_controls(a, b, 1'b0);
			check_ports($sformatf("stick combination %0d", i));
		end
		end_test("Krooz'r stick");

		load_write(`MCR2_IDX_GAME, '0, 8'd7);
		for (int i = 0; i < 5; i++) begin
			a = rand_ctrl();
			b = rand_ctrl();
			drive_controls(a, b, 1'b0);
			check_ports($sformatf("unknown game vector %0d", i));
		end
		end_test("unknown game");

		$display("tests 6, failed %0d, checks %0d, wrong values %0d",
			tests_failed, checks, errors);
		if (tests_failed == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* mcr2_inputs.f */
+incdir+source
source/mcr2_inputs_pkg.sv
source/dl_decoder.sv
source/spinner.sv
source/port_mapper.sv
source/mcr2_inputs.sv
test/mcr2_inputs_props.sv
test/tb_mcr2_inputs.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mcr2_inputs -f mcr2_inputs.f

output=$(./obj_dir/Vtb_mcr2_inputs || true)
echo "$output"
if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
